// File: src/slot_defines.svh
`ifndef SLOT_DEFINES_SVH
`define SLOT_DEFINES_SVH

// slots per destination, also the depth of every destination FIFO.
`define SLOT_MAX_COUNT 8

// number of destination ports.
`define SLOT_DEST_COUNT 16

`endif

// File: src/slot_pkg.sv
`default_nettype none

`include "slot_defines.svh"

package slot_pkg;

  // slot numbers run from 1 to SLOT_MAX_COUNT, 0 is kept for "no slot".
  typedef logic [$clog2(`SLOT_MAX_COUNT+1)-1:0] slot_t;

  typedef logic [$clog2(`SLOT_DEST_COUNT)-1:0] dest_t;

  typedef logic [`SLOT_DEST_COUNT-1:0] dest_mask_t; // one-hot or empty.

  // configuration request: clear a destination and refill it.
  typedef struct packed {
    dest_t dest;
    slot_t count;  // clipped to SLOT_MAX_COUNT by the loader.
  } load_req_t;

  typedef struct packed {
    dest_t dest;
  } alloc_req_t;

  typedef struct packed {
    dest_t dest;
    slot_t slot;
  } release_req_t;

  typedef struct packed {
    logic  ok;    // low when the destination had no free slot.
    slot_t slot;  // zero on refusal.
  } alloc_rsp_t;

endpackage

`default_nettype wire

// File: src/slot_fifo_loader.sv
`timescale 1ns/10ps
`default_nettype none

`include "slot_defines.svh"

module slot_fifo_loader (
  input  logic                   clk,
  input  logic                   rst,

  input  logic                   load_valid,
  input  slot_pkg::load_req_t    load_req,
  output logic                   load_ready,

  // no ready here, the loader owns the FIFO while loading.
  output slot_pkg::dest_mask_t   clear_fifo,
  output slot_pkg::dest_mask_t   slot_valid,
  output slot_pkg::slot_t        slot
);

  typedef enum logic [1:0] {
    IDLE,
    INIT,
    PROC
  } state_t;

  localparam slot_pkg::slot_t MAX_COUNT = slot_pkg::slot_t'(`SLOT_MAX_COUNT);
  localparam slot_pkg::slot_t ONE       = slot_pkg::slot_t'(1);

  state_t               state_r;
  state_t               state_n;
  slot_pkg::dest_mask_t dest_dec_r;
  slot_pkg::slot_t      count_r;
  slot_pkg::slot_t      remain_r;
  slot_pkg::slot_t      count_clip;
  logic                 load_fire;
  logic                 load_done;

  assign load_fire  = load_valid && load_ready;
  assign count_clip = (count_r > MAX_COUNT) ? MAX_COUNT : count_r;
  assign load_done  = (state_r == PROC) && (remain_r == ONE); // slot 1 is the last push.

  always_comb begin
    state_n = state_r;
    case (state_r)
      IDLE: begin
        if (load_fire) begin
          state_n = INIT;
        end
      end
      INIT: begin
        if (count_clip == '0) begin
          state_n = IDLE; // zero count only clears.
        end else begin
          state_n = PROC;
        end
      end
      PROC: begin
        if (load_done) begin
          state_n = IDLE;
        end
      end
      default: begin
        state_n = IDLE;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state_r <= IDLE;
    end else begin
      state_r <= state_n;
    end
  end

  // request is held for the whole load.
  always_ff @(posedge clk) begin
    if (load_fire) begin
      dest_dec_r <= slot_pkg::dest_mask_t'(1) << load_req.dest;
      count_r    <= load_req.count;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      remain_r <= '0;
    end else if (state_r == INIT) begin
      remain_r <= count_clip;
    end else if (state_r == PROC) begin
      remain_r <= remain_r - ONE;
    end
  end

  assign load_ready = (state_r == IDLE);
  assign clear_fifo = (state_r == INIT) ? dest_dec_r : '0;
  assign slot_valid = (state_r == PROC) ? dest_dec_r : '0;
  assign slot       = remain_r; // counts down k to 1.

endmodule

`default_nettype wire

// File: src/slot_fifo.sv
`timescale 1ns/10ps
`default_nettype none

module slot_fifo #(
  parameter int DEPTH = 8
) (
  input  logic            clk,
  input  logic            rst,

  input  logic            clear,
  input  logic            push,
  input  slot_pkg::slot_t push_slot,
  input  logic            pop,

  output slot_pkg::slot_t head,
  output logic            empty,
  output logic            full
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  localparam logic [PTR_W-1:0] PTR_LAST = PTR_W'(DEPTH - 1);
  localparam logic [CNT_W-1:0] CNT_FULL = CNT_W'(DEPTH);

  slot_pkg::slot_t  mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic             do_push;
  logic             do_pop;

  assign empty = (count == '0);
  assign full  = (count == CNT_FULL);

  assign do_pop  = pop && !empty;
  assign do_push = push && (!full || do_pop); // a pop frees a word in the same cycle.

  always_ff @(posedge clk) begin
    if (do_push) begin
      mem[wr_ptr] <= push_slot;
    end
  end

  always_ff @(posedge clk) begin
    if (rst || clear) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr <= (wr_ptr == PTR_LAST) ? '0 : wr_ptr + 1'b1;
      end
      if (do_pop) begin
        rd_ptr <= (rd_ptr == PTR_LAST) ? '0 : rd_ptr + 1'b1;
      end
      case ({do_push, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count; // both or neither.
      endcase
    end
  end

  assign head = mem[rd_ptr]; // show-ahead.

endmodule

`default_nettype wire

// File: src/slot_allocator.sv
`timescale 1ns/10ps
`default_nettype none

`include "slot_defines.svh"

module slot_allocator (
  input  logic                   clk,
  input  logic                   rst,

  // from the loader.
  input  slot_pkg::dest_mask_t   clear_fifo,
  input  slot_pkg::dest_mask_t   slot_valid,
  input  slot_pkg::slot_t        slot,

  input  logic                   alloc_valid,
  input  slot_pkg::alloc_req_t   alloc_req,

  input  logic                   release_valid,
  input  slot_pkg::release_req_t release_req,

  output logic                   rsp_valid,
  output slot_pkg::alloc_rsp_t   rsp
);

  localparam int DEST_COUNT = `SLOT_DEST_COUNT;

  slot_pkg::dest_mask_t alloc_sel;
  slot_pkg::dest_mask_t release_sel;
  slot_pkg::dest_mask_t fifo_push;
  slot_pkg::dest_mask_t fifo_pop;
  slot_pkg::dest_mask_t fifo_empty;
  slot_pkg::dest_mask_t fifo_full;
  slot_pkg::slot_t      push_slot [DEST_COUNT];
  slot_pkg::slot_t      fifo_head [DEST_COUNT];
  slot_pkg::slot_t      sel_head;
  logic                 sel_ok;

  assign alloc_sel   = alloc_valid ? slot_pkg::dest_mask_t'(1) << alloc_req.dest : '0;
  assign release_sel = release_valid ? slot_pkg::dest_mask_t'(1) << release_req.dest : '0;

  for (genvar i = 0; i < DEST_COUNT; i++) begin : g_dest

    // loader and release never overlap, the loader wins if they did.
    assign fifo_push[i] = slot_valid[i] || release_sel[i];
    assign push_slot[i] = slot_valid[i] ? slot : release_req.slot;
    assign fifo_pop[i]  = alloc_sel[i] && !fifo_empty[i];

    slot_fifo #(
      .DEPTH     (`SLOT_MAX_COUNT)
    ) i_fifo (
      .clk       (clk),
      .rst       (rst),
      .clear     (clear_fifo[i]),
      .push      (fifo_push[i]),
      .push_slot (push_slot[i]),
      .pop       (fifo_pop[i]),
      .head      (fifo_head[i]),
      .empty     (fifo_empty[i]),
      .full      (fifo_full[i])
    );

  end

  assign sel_ok   = !fifo_empty[alloc_req.dest];
  assign sel_head = fifo_head[alloc_req.dest];

  always_ff @(posedge clk) begin
    if (rst) begin
      rsp_valid <= 1'b0;
    end else begin
      rsp_valid <= alloc_valid;
    end
  end

  // head is sampled in the same cycle as the pop.
  always_ff @(posedge clk) begin
    if (alloc_valid) begin
      rsp.ok   <= sel_ok;
      rsp.slot <= sel_ok ? sel_head : '0;
    end
  end

endmodule

`default_nettype wire

// File: src/slot_manager_top.sv
`timescale 1ns/10ps
`default_nettype none

module slot_manager_top (
  input  logic                   clk,
  input  logic                   rst,

  // configuration.
  input  logic                   load_valid,
  input  slot_pkg::load_req_t    load_req,
  output logic                   load_ready,

  // traffic strobes, legal only while load_ready is high.
  input  logic                   alloc_valid,
  input  slot_pkg::alloc_req_t   alloc_req,

  input  logic                   release_valid,
  input  slot_pkg::release_req_t release_req,

  output logic                   rsp_valid,
  output slot_pkg::alloc_rsp_t   rsp
);

  slot_pkg::dest_mask_t clear_fifo;
  slot_pkg::dest_mask_t slot_valid;
  slot_pkg::slot_t      slot;

  slot_fifo_loader i_loader (
    .clk        (clk),
    .rst        (rst),
    .load_valid (load_valid),
    .load_req   (load_req),
    .load_ready (load_ready),
    .clear_fifo (clear_fifo),
    .slot_valid (slot_valid),
    .slot       (slot)
  );

  slot_allocator i_allocator (
    .clk           (clk),
    .rst           (rst),
    .clear_fifo    (clear_fifo),
    .slot_valid    (slot_valid),
    .slot          (slot),
    .alloc_valid   (alloc_valid),
    .alloc_req     (alloc_req),
    .release_valid (release_valid),
    .release_req   (release_req),
    .rsp_valid     (rsp_valid),
    .rsp           (rsp)
  );

endmodule

`default_nettype wire

// File: sim/slot_manager_assert.sv
`timescale 1ns/10ps
`default_nettype none

`include "slot_defines.svh"

module slot_manager_assert (
  input wire logic                 clk,
  input wire logic                 rst,
  input wire slot_pkg::dest_mask_t clear_fifo,
  input wire slot_pkg::dest_mask_t slot_valid,
  input wire slot_pkg::slot_t      slot,
  input wire slot_pkg::dest_mask_t fifo_push,
  input wire slot_pkg::dest_mask_t fifo_pop,
  input wire slot_pkg::dest_mask_t fifo_full,
  input wire logic                 alloc_valid,
  input wire logic                 release_valid
);

  localparam slot_pkg::slot_t MAX_SLOT = slot_pkg::slot_t'(`SLOT_MAX_COUNT);

  int fail_count = 0; // failed assertions so far.

  // a pop in the same cycle makes room.
  assert property (@(posedge clk) disable iff (rst)
    (fifo_push & fifo_full & ~fifo_pop) == '0)
    else begin
      fail_count++;
      $error("push into a full destination FIFO");
    end

  assert property (@(posedge clk) disable iff (rst)
    (alloc_valid || release_valid) |-> (clear_fifo == '0 && slot_valid == '0))
    else begin
      fail_count++;
      $error("alloc or release while the loader owns the FIFOs");
    end

  // one destination per push, and slot 0 is never loaded.
  assert property (@(posedge clk) disable iff (rst)
    (slot_valid != '0) |-> ($onehot(slot_valid) && slot != '0 && slot <= MAX_SLOT))
    else begin
      fail_count++;
      $error("loader push is not one-hot or carries a slot out of range");
    end

endmodule

bind slot_allocator slot_manager_assert i_assert (.*);

`default_nettype wire

// File: sim/slot_manager_tb.sv
`timescale 1ns/10ps
`default_nettype none

`include "slot_defines.svh"

module slot_manager_tb;

  localparam int DEST_COUNT     = `SLOT_DEST_COUNT;
  localparam int MAX_COUNT      = `SLOT_MAX_COUNT;
  localparam int NUM_OPS        = 400;
  localparam int TIMEOUT_CYCLES = NUM_OPS * 12; // longest load takes 12 cycles.
  localparam int DRIVE_DELAY    = 10;
  localparam int SEED           = 47;

  logic                   clk;
  logic                   rst;
  logic                   load_valid;
  slot_pkg::load_req_t    load_req;
  logic                   load_ready;
  logic                   alloc_valid;
  slot_pkg::alloc_req_t   alloc_req;
  logic                   release_valid;
  slot_pkg::release_req_t release_req;
  logic                   rsp_valid;
  slot_pkg::alloc_rsp_t   rsp;

  int free_q [DEST_COUNT][$]; // free slots per destination, head first.
  int held_q [DEST_COUNT][$]; // slots handed out and not yet released.
  int cycle_count;

  slot_manager_top i_dut (
    .clk           (clk),
    .rst           (rst),
    .load_valid    (load_valid),
    .load_req      (load_req),
    .load_ready    (load_ready),
    .alloc_valid   (alloc_valid),
    .alloc_req     (alloc_req),
    .release_valid (release_valid),
    .release_req   (release_req),
    .rsp_valid     (rsp_valid),
    .rsp           (rsp)
  );

  always #50 clk = ~clk;

  always @(posedge clk) begin
    cycle_count = cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("test failed");
      $fatal(1, "run stopped by the cycle limit");
    end
  end

  task automatic check_value(input string name, input int expected, input int actual);
    assert (expected == actual) else begin
      $display("** Error at %0t ns: %s expected %0d, actual %0d", $time, name, expected,
               actual);
      $display("test failed");
      $fatal(1, "stopping at the first mismatch");
    end
  endtask

  // first destination at or after start that holds allocated slots, -1 if none.
  function automatic int find_held_dest(input int start);
    int d;
    for (int i = 0; i < DEST_COUNT; i++) begin
      d = (start + i) % DEST_COUNT;
      if (held_q[d].size() > 0) begin
        return d;
      end
    end
    return -1;
  endfunction

  task automatic run_load(input int dest, input int count);
    int k;
    int cycles;
    k = (count > MAX_COUNT) ? MAX_COUNT : count;
    @(posedge clk);
    #DRIVE_DELAY;
    check_value("load_ready", 1, load_ready);
    load_valid    = 1'b1;
    load_req.dest = slot_pkg::dest_t'(dest);
    load_req.count = slot_pkg::slot_t'(count);
    @(posedge clk); // request taken here.
    #DRIVE_DELAY;
    load_valid = 1'b0;
    cycles = 1;
    @(negedge clk);
    while (!load_ready) begin
      @(negedge clk);
      cycles++;
    end
    check_value("load_ready latency", k + 2, cycles);
    free_q[dest].delete();
    held_q[dest].delete(); // old slots of this destination are void now.
    for (int s = k; s >= 1; s--) begin
      free_q[dest].push_back(s);
    end
  endtask

  task automatic run_traffic(input bit do_alloc, input int a_dest,
                             input bit do_release, input int r_dest);
    int idx;
    int r_slot;
    int exp_ok;
    int exp_slot;
    r_slot = 0;
    if (do_release) begin
      idx    = $urandom % held_q[r_dest].size();
      r_slot = held_q[r_dest][idx];
      held_q[r_dest].delete(idx);
    end
    @(posedge clk);
    #DRIVE_DELAY;
    alloc_valid      = do_alloc;
    alloc_req.dest   = slot_pkg::dest_t'(a_dest);
    release_valid    = do_release;
    release_req.dest = slot_pkg::dest_t'(r_dest);
    release_req.slot = slot_pkg::slot_t'(r_slot);
    // alloc sees the FIFO before the release lands.
    exp_ok   = 0;
    exp_slot = 0;
    if (do_alloc && free_q[a_dest].size() > 0) begin
      exp_ok   = 1;
      exp_slot = free_q[a_dest].pop_front();
      held_q[a_dest].push_back(exp_slot);
    end
    if (do_release) begin
      free_q[r_dest].push_back(r_slot);
    end
    @(posedge clk);
    #DRIVE_DELAY;
    alloc_valid   = 1'b0;
    release_valid = 1'b0;
    @(negedge clk);
    check_value("rsp_valid", int'(do_alloc), int'(rsp_valid));
    if (do_alloc) begin
      check_value("rsp.ok", exp_ok, int'(rsp.ok));
      check_value("rsp.slot", exp_slot, int'(rsp.slot));
    end
  endtask

  initial begin
    int pick;
    int focus_dest;
    int dest;
    int r_dest;
    clk           = 1'b0;
    rst           = 1'b1;
    load_valid    = 1'b0;
    load_req      = '0;
    alloc_valid   = 1'b0;
    alloc_req     = '0;
    release_valid = 1'b0;
    release_req   = '0;
    cycle_count   = 0;
    void'($urandom(SEED));
    focus_dest    = 0;

    repeat (3) @(posedge clk);
    #DRIVE_DELAY;
    rst = 1'b0;
    @(negedge clk);
    check_value("load_ready", 1, int'(load_ready));
    check_value("rsp_valid", 0, int'(rsp_valid));

    // every FIFO starts empty.
    for (int d = 0; d < DEST_COUNT; d++) begin
      run_traffic(1'b1, d, 1'b0, 0);
    end

    for (int op = DEST_COUNT; op < NUM_OPS; op++) begin
      pick = $urandom % 100;
      dest = (($urandom % 2) == 0) ? focus_dest : int'($urandom % DEST_COUNT);
      if (pick < 5) begin
        focus_dest = $urandom % DEST_COUNT;
        run_load(focus_dest, $urandom % 11);
      end else if (pick < 55) begin
        run_traffic(1'b1, dest, 1'b0, 0);
      end else if (pick < 85) begin
        r_dest = find_held_dest(dest);
        if (r_dest < 0) begin
          run_traffic(1'b1, dest, 1'b0, 0);
        end else begin
          run_traffic(1'b0, 0, 1'b1, r_dest);
        end
      end else begin
        r_dest = find_held_dest(dest); // same destination for both strobes.
        if (r_dest < 0) begin
          run_traffic(1'b1, dest, 1'b0, 0);
        end else begin
          run_traffic(1'b1, r_dest, 1'b1, r_dest);
        end
      end
    end

    repeat (2) @(posedge clk);
    if (i_dut.i_allocator.i_assert.fail_count == 0) begin
      $display("test passed");
      $finish;
    end else begin
      $display("test failed");
      $fatal(1, "bound assertions reported failures");
    end
  end

endmodule

`default_nettype wire

// File: vlog.f
+incdir+src
src/slot_pkg.sv
src/slot_fifo_loader.sv
src/slot_fifo.sv
src/slot_allocator.sv
src/slot_manager_top.sv
sim/slot_manager_assert.sv
sim/slot_manager_tb.sv

// File: Bender.yml
package:
  name: slot_manager

export_include_dirs:
  - src

sources:
  - include_dirs:
      - src
    files:
      - src/slot_pkg.sv
      - src/slot_fifo_loader.sv
      - src/slot_fifo.sv
      - src/slot_allocator.sv
      - src/slot_manager_top.sv

  - target: simulation
    include_dirs:
      - src
    files:
      - sim/slot_manager_assert.sv
      - sim/slot_manager_tb.sv
